// ==== sim.f ====
+incdir+common
+incdir+test
common/rdbuf_pkg.sv
fifo_buffer/slot_fifo_bram.sv
fifo_buffer/claim_fifo_buffer.sv
src/burst_read_requester.sv
src/beat_memory.sv
src/read_buffer_top.sv
test/read_buffer_tb.sv

// ==== test/read_buffer_vectors.svh ====
`ifndef READ_BUFFER_VECTORS_SVH
`define READ_BUFFER_VECTORS_SVH

// One stimulus row: one burst command plus the consumer behavior while it runs
typedef struct packed
{
    logic rewrite;
    logic [7:0] ready_pat;
    t_burst_len len;
    t_addr addr;
} row_t;

localparam int N_ROWS = 29;

function automatic row_t row_at(input int idx);
    row_t row;
    // Columns: rewrite words first, out_ready pattern (bit 0 first), length, address
    case (idx)
        // Free-running consumer, single beats and full bursts
        0: row = {1'b0, 8'hFF, 3'd1, 6'd0};
        1: row = {1'b0, 8'hFF, 3'd4, 6'd1};
        2: row = {1'b0, 8'hFF, 3'd4, 6'd5};
        3: row = {1'b0, 8'hFF, 3'd4, 6'd58};
        4: row = {1'b0, 8'hFF, 3'd1, 6'd9};
        5: row = {1'b0, 8'hFF, 3'd1, 6'd10};
        6: row = {1'b0, 8'hFF, 3'd1, 6'd11};
        // Consumer stopped, claims pile up
        7: row = {1'b0, 8'h00, 3'd4, 6'd20};
        8: row = {1'b0, 8'h00, 3'd4, 6'd24};
        9: row = {1'b0, 8'h00, 3'd4, 6'd28};
        10: row = {1'b0, 8'h00, 3'd4, 6'd32};
        11: row = {1'b0, 8'h00, 3'd4, 6'd36};
        12: row = {1'b0, 8'h00, 3'd4, 6'd40};
        13: row = {1'b0, 8'h00, 3'd4, 6'd44};
        // Slow release, this one should wait on almost_full
        14: row = {1'b0, 8'h80, 3'd4, 6'd48};
        15: row = {1'b0, 8'hFF, 3'd2, 6'd52};
        // Partial stalls with bursts still in flight
        16: row = {1'b0, 8'hA5, 3'd2, 6'd3};
        17: row = {1'b0, 8'h3C, 3'd3, 6'd6};
        18: row = {1'b0, 8'h0F, 3'd4, 6'd12};
        19: row = {1'b0, 8'hF0, 3'd1, 6'd33};
        20: row = {1'b0, 8'hC3, 3'd4, 6'd50};
        // Memory overwritten between rows, then read back
        21: row = {1'b1, 8'hFF, 3'd4, 6'd1};
        22: row = {1'b0, 8'hFF, 3'd2, 6'd1};
        23: row = {1'b1, 8'h5A, 3'd3, 6'd40};
        24: row = {1'b0, 8'hFF, 3'd4, 6'd40};
        25: row = {1'b1, 8'h77, 3'd1, 6'd10};
        26: row = {1'b0, 8'hFF, 3'd4, 6'd8};
        27: row = {1'b1, 8'hE7, 3'd4, 6'd60};
        28: row = {1'b0, 8'hFF, 3'd4, 6'd60};
        default: row = '0;
    endcase
    return row;
endfunction

`endif

// ==== test/read_buffer_tb.sv ====
`timescale 1ns/100ps
`include "rdbuf_defines.svh"

module read_buffer_tb;

    import rdbuf_pkg::*;

    `include "read_buffer_vectors.svh"

    localparam int CLK_HALF = 50;
    localparam int DRIVE_DELAY = 5;
    localparam int RESET_CYCLES = 8;
    localparam int N_WORDS = 2 ** `RDBUF_ADDR_BITS;
    localparam logic [31:0] RAND_SEED = 32'h5d1e_7668;

    logic clk = 1'b0;
    logic reset_n;
    logic cmd_valid;
    logic cmd_ready;
    t_addr cmd_addr;
    t_burst_len cmd_len;
    logic wr_en;
    t_addr wr_addr;
    t_data wr_data;
    logic out_valid;
    logic out_ready;
    t_data out_data;

    // Reference copy of the memory contents
    t_data shadow [N_WORDS];
    // Words accepted but not yet delivered, in command order
    t_data exp_q [$];
    t_data exp_word;

    int cycle = 0;
    int data_errs = 0;
    int flow_errs = 0;
    int beats_seen = 0;
    int blocked_rows = 0;

    // Consumer pattern, rotated one bit per cycle
    logic [7:0] cur_pat = 8'h00;
    int phase = 0;

    read_buffer_top read_buffer_top_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_addr(cmd_addr),
        .cmd_len(cmd_len),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // Sum of all burst lengths, sizes the watchdog
    function automatic int table_beats();
        int total;
        row_t row;
        total = 0;
        for (int i = 0; i < N_ROWS; i++)
        begin
            row = row_at(i);
            total += int'(row.len);
        end
        return total;
    endfunction

    // Advance one clock, then drive the consumer side
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        out_ready = cur_pat[phase];
        phase = (phase + 1) % 8;
    endtask

    // New consumer pattern takes effect right away
    task automatic apply_ready_pattern(input logic [7:0] pat);
        cur_pat = pat;
        out_ready = pat[0];
        phase = 1;
    endtask

    // Fresh random words into memory and shadow, one per cycle
    task automatic rewrite_words(input t_addr addr, input t_burst_len len);
        for (int i = 0; i < int'(len); i++)
        begin
            wr_en = 1'b1;
            wr_addr = t_addr'(addr + i);
            wr_data = $urandom;
            shadow[wr_addr] = wr_data;
            next_cycle();
        end
        wr_en = 1'b0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d data errors, %0d flow errors, %0d beats checked",
            data_errs, flow_errs, beats_seen);
    endtask

    // Output monitor, samples between edges where everything is settled
    always @(negedge clk)
    begin
        if (reset_n === 1'b1)
        begin
            if (out_valid === 1'b1 && out_ready === 1'b1)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    $display("Beat delivered at cycle %0d with no command behind it", cycle);
                    flow_errs++;
                end
                if (exp_q.size() != 0)
                begin
                    exp_word = exp_q.pop_front();
                    assert (out_data === exp_word)
                    else
                    begin
                        $display("ERROR: out_data = %h, expected %h (beat %0d)",
                            out_data, exp_word, beats_seen);
                        data_errs++;
                    end
                    beats_seen++;
                end
            end
            // Accepted but undelivered beats must fit in the buffer
            assert (exp_q.size() <= `RDBUF_N_ENTRIES)
            else
            begin
                $display("%0d beats outstanding at cycle %0d, more than the buffer holds",
                    exp_q.size(), cycle);
                flow_errs++;
            end
        end
    end

    // Watchdog, about 20 cycles per beat plus reset, preload and rewrites
    initial
    begin
        int limit;
        limit = table_beats() * 20 + 400;
        repeat (limit) @(posedge clk);
        $display("Run did not finish within %0d cycles", limit);
        flow_errs++;
        print_summary();
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        row_t row;
        int earliest;
        int accept;
        int last_accept;
        int last_len;
        int wait_n;

        void'($urandom(RAND_SEED));
        reset_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_addr = '0;
        cmd_len = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        out_ready = 1'b0;
        last_accept = 0;
        last_len = 0;

        // Outputs quiet through reset, skipping the first edge
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            next_cycle();
            assert (cmd_ready === 1'b0)
            else
            begin
                $display("ERROR: cmd_ready = %h in reset, expected 0", cmd_ready);
                flow_errs++;
            end
            assert (out_valid === 1'b0)
            else
            begin
                $display("ERROR: out_valid = %h in reset, expected 0", out_valid);
                flow_errs++;
            end
        end
        reset_n = 1'b1;

        // cmd_ready within two cycles of reset release
        wait_n = 0;
        while (cmd_ready !== 1'b1 && wait_n < 3)
        begin
            next_cycle();
            wait_n++;
        end
        assert (cmd_ready === 1'b1 && wait_n <= 2)
        else
        begin
            $display("ERROR: cmd_ready = %h, expected 1 within 2 cycles of reset", cmd_ready);
            flow_errs++;
        end

        // Preload the whole memory
        for (int a = 0; a < N_WORDS; a++)
        begin
            wr_en = 1'b1;
            wr_addr = t_addr'(a);
            wr_data = $urandom;
            shadow[a] = wr_data;
            next_cycle();
        end
        wr_en = 1'b0;

        for (int r = 0; r < N_ROWS; r++)
        begin
            row = row_at(r);
            if (row.rewrite)
            begin
                // Previous burst must have read memory before it changes
                while (cycle < last_accept + last_len + 1)
                    next_cycle();
                rewrite_words(row.addr, row.len);
            end
            apply_ready_pattern(row.ready_pat);
            cmd_addr = row.addr;
            cmd_len = row.len;
            cmd_valid = 1'b1;

            // Earliest edge a correct requester could take it
            earliest = cycle + 1;
            if (last_accept + last_len + 1 > earliest)
                earliest = last_accept + last_len + 1;

            while (cmd_ready !== 1'b1)
                next_cycle();
            accept = cycle + 1;

            assert (accept >= last_accept + last_len + 1)
            else
            begin
                $display("Command %0d taken at cycle %0d while the previous burst was issuing",
                    r, accept);
                flow_errs++;
            end
            // Held off past the busy time means almost_full stopped it
            if (accept > earliest)
                blocked_rows++;

            for (int i = 0; i < int'(row.len); i++)
                exp_q.push_back(shadow[t_addr'(row.addr + i)]);

            next_cycle();
            cmd_valid = 1'b0;
            last_accept = accept;
            last_len = int'(row.len);
        end

        // Drain whatever is left
        apply_ready_pattern(8'hFF);
        while (exp_q.size() != 0)
            next_cycle();
        repeat (3) next_cycle();

        assert (out_valid === 1'b0)
        else
        begin
            $display("ERROR: out_valid = %h after drain, expected 0", out_valid);
            flow_errs++;
        end
        assert (blocked_rows > 0)
        else
        begin
            $display("Stalled consumer never held off a command");
            flow_errs++;
        end

        print_summary();
        if (data_errs == 0 && flow_errs == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== src/read_buffer_top.sv ====
`timescale 1ns/100ps
`include "rdbuf_defines.svh"

module read_buffer_top
(
    input  logic clk,
    input  logic reset_n,

    // Burst read commands
    input  logic cmd_valid,
    output logic cmd_ready,
    input  rdbuf_pkg::t_addr cmd_addr,
    input  rdbuf_pkg::t_burst_len cmd_len,

    // Memory fill
    input  logic wr_en,
    input  rdbuf_pkg::t_addr wr_addr,
    input  rdbuf_pkg::t_data wr_data,

    // Ordered read data out
    output logic out_valid,
    input  logic out_ready,
    output rdbuf_pkg::t_data out_data
);

    import rdbuf_pkg::*;

    // Requester to buffer
    logic alloc_en;
    t_burst_len alloc_cnt;
    logic almost_full;

    // Requester to memory
    logic rd_en;
    t_addr rd_addr;

    // Memory to buffer
    logic resp_en;
    t_data resp_data;

    logic deq_en;

    // Pop on every output transfer
    assign deq_en = out_valid && out_ready;

    burst_read_requester requester_i
    (
        .clk,
        .reset_n,
        .cmd_valid,
        .cmd_ready,
        .cmd_addr,
        .cmd_len,
        .almost_full,
        .alloc_en,
        .alloc_cnt,
        .rd_en,
        .rd_addr
    );

    beat_memory memory_i
    (
        .clk,
        .reset_n,
        .wr_en,
        .wr_addr,
        .wr_data,
        .rd_en,
        .rd_addr,
        .resp_en,
        .resp_data
    );

    // Claim-ahead buffer sized from the shared macros
    claim_fifo_buffer
    #(
        .N_ENTRIES(`RDBUF_N_ENTRIES),
        .DATA_BITS(`RDBUF_DATA_BITS),
        .MAX_ALLOC(`RDBUF_MAX_BURST)
    )
    buffer_i
    (
        .clk,
        .reset_n,
        .alloc_en,
        .alloc_cnt,
        .almost_full,
        .enq_data(resp_data),
        .enq_en(resp_en),
        .first(out_data),
        .deq_en,
        .not_empty(out_valid)
    );

endmodule

// ==== src/beat_memory.sv ====
`timescale 1ns/100ps

module beat_memory
(
    input  logic clk,
    input  logic reset_n,

    // Fill port, no handshake
    input  logic wr_en,
    input  rdbuf_pkg::t_addr wr_addr,
    input  rdbuf_pkg::t_data wr_data,

    // Beat read request
    input  logic rd_en,
    input  rdbuf_pkg::t_addr rd_addr,

    // Response two cycles after rd_en
    output logic resp_en,
    output rdbuf_pkg::t_data resp_data
);

    import rdbuf_pkg::*;

    // One word per address
    localparam int N_WORDS = 2 ** $bits(t_addr);

    t_data mem [N_WORDS];

    // First stage, RAM output register
    t_data rd_data_q;
    logic rd_valid_q;

    // Storage with synchronous read
    // Write and read share one block so a same-address collision returns old data
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_data_q <= mem[rd_addr];
    end

    // Second stage, output register
    // Fully pipelined, a new read may enter every cycle
    always_ff @(posedge clk)
    begin
        if (rd_valid_q)
            resp_data <= rd_data_q;
    end

    // Valid pipeline tracking the two data stages
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_valid_q <= 1'b0;
            resp_en <= 1'b0;
        end
        else
        begin
            rd_valid_q <= rd_en;
            // No stall input here
            // The buffer always has a claimed slot for this beat
            resp_en <= rd_valid_q;
        end
    end

endmodule

// ==== src/burst_read_requester.sv ====
`timescale 1ns/100ps

module burst_read_requester
(
    input  logic clk,
    input  logic reset_n,

    // Burst command in
    input  logic cmd_valid,
    output logic cmd_ready,
    input  rdbuf_pkg::t_addr cmd_addr,
    input  rdbuf_pkg::t_burst_len cmd_len,

    // Slot claims toward the buffer
    input  logic almost_full,
    output logic alloc_en,
    output rdbuf_pkg::t_burst_len alloc_cnt,

    // Beat reads toward the memory
    output logic rd_en,
    output rdbuf_pkg::t_addr rd_addr
);

    import rdbuf_pkg::*;

    t_req_state state;
    t_req_state state_next;

    // Address of the next beat and beats still to issue
    t_addr cur_addr;
    t_burst_len beats_left;

    logic cmd_accept;
    logic last_beat;

    // New work only while idle and the buffer has room for a full burst
    assign cmd_ready = (state == REQ_IDLE) && !almost_full;
    assign cmd_accept = cmd_valid && cmd_ready;

    // Whole burst claimed in the accept cycle
    assign alloc_en = cmd_accept;
    assign alloc_cnt = cmd_len;

    // One beat per issue cycle
    assign rd_en = (state == REQ_ISSUE);
    assign rd_addr = cur_addr;

    assign last_beat = (beats_left == t_burst_len'(1));

    // Next state
    always_comb
    begin
        state_next = state;
        case (state)
            REQ_IDLE:
            begin
                if (cmd_accept)
                    state_next = REQ_ISSUE;
            end
            REQ_ISSUE:
            begin
                // Burst of L beats spends exactly L cycles here
                if (last_beat)
                    state_next = REQ_IDLE;
            end
        endcase
    end

    // State and beat count
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= REQ_IDLE;
            beats_left <= '0;
        end
        else
        begin
            state <= state_next;
            if (cmd_accept)
                beats_left <= cmd_len;
            else if (rd_en)
                beats_left <= beats_left - t_burst_len'(1);
        end
    end

    // Beat address, loaded on accept and stepped per beat
    always_ff @(posedge clk)
    begin
        if (cmd_accept)
            cur_addr <= cmd_addr;
        else if (rd_en)
            cur_addr <= cur_addr + t_addr'(1);
    end

endmodule

// ==== fifo_buffer/claim_fifo_buffer.sv ====
`timescale 1ns/100ps

module claim_fifo_buffer
#(
    parameter int N_ENTRIES = 32,
    parameter int DATA_BITS = 32,
    // Largest claim in a single cycle
    parameter int MAX_ALLOC = 4
)
(
    input  logic clk,
    input  logic reset_n,

    // Slot claims, control only, no payload
    input  logic alloc_en,
    input  logic [$clog2(MAX_ALLOC):0] alloc_cnt,
    output logic almost_full,

    // Payload arrives later into slots already claimed
    input  logic [DATA_BITS-1:0] enq_data,
    input  logic enq_en,

    // In-order drain
    output logic [DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    localparam int CNT_BITS = $clog2(N_ENTRIES) + 1;

    // Thresholds for the registered almost_full
    // Claim cycles need room for one more worst-case claim behind them
    localparam logic [CNT_BITS-1:0] MARK_IDLE = CNT_BITS'(N_ENTRIES - MAX_ALLOC);
    localparam logic [CNT_BITS-1:0] MARK_CLAIM = CNT_BITS'(N_ENTRIES - 2 * MAX_ALLOC);

    // Slots claimed and not yet dequeued
    logic [CNT_BITS-1:0] space_used;
    logic [CNT_BITS-1:0] space_used_next;

    logic [CNT_BITS-1:0] alloc_ext;
    logic [CNT_BITS-1:0] used_add;
    logic [CNT_BITS-1:0] used_sub;
    logic [CNT_BITS-1:0] used_add_sub;

    assign alloc_ext = CNT_BITS'(alloc_cnt);

    // All three sums in parallel
    assign used_add = space_used + alloc_ext;
    assign used_sub = space_used - CNT_BITS'(1);
    assign used_add_sub = used_add - CNT_BITS'(1);

    // Pick the result after the adders to keep the select off the carry chain
    always_comb
    begin
        case ({alloc_en, deq_en})
            2'b10: space_used_next = used_add;
            2'b01: space_used_next = used_sub;
            2'b11: space_used_next = used_add_sub;
            default: space_used_next = space_used;
        endcase
    end

    // Counter and almost_full
    // Flag looks at the current count with the MAX_ALLOC margin, not at alloc_cnt
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            space_used <= '0;
            // Read as full until the first clock out of reset
            almost_full <= 1'b1;
        end
        else
        begin
            space_used <= space_used_next;
            if (alloc_en)
                almost_full <= (space_used > MARK_CLAIM);
            else
                almost_full <= (space_used > MARK_IDLE);
        end
    end

    // Data path is an ordinary FIFO
    // Claims guarantee room, so its full flag goes nowhere
    slot_fifo_bram
    #(
        .N_ENTRIES(N_ENTRIES),
        .DATA_BITS(DATA_BITS)
    )
    fifo_i
    (
        .clk,
        .reset_n,
        .enq_data,
        .enq_en,
        .not_full(),
        .first,
        .deq_en,
        .not_empty
    );

endmodule

// ==== fifo_buffer/slot_fifo_bram.sv ====
`timescale 1ns/100ps

module slot_fifo_bram
#(
    parameter int N_ENTRIES = 32,
    parameter int DATA_BITS = 32
)
(
    input  logic clk,
    input  logic reset_n,

    // Write side
    input  logic [DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,

    // Ordered read side, first word is registered
    output logic [DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    // Pointers wrap on their own, so depth is a power of two
    localparam int PTR_BITS = $clog2(N_ENTRIES);
    localparam int CNT_BITS = PTR_BITS + 1;

    // Storage array, meant to map onto block RAM
    logic [DATA_BITS-1:0] mem [N_ENTRIES];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] rd_ptr_next;
    logic [CNT_BITS-1:0] count;
    logic fwd_enq;

    // Head address as it will be after this cycle's dequeue
    assign rd_ptr_next = deq_en ? rd_ptr + PTR_BITS'(1) : rd_ptr;

    // Word being written is the next head
    // Only happens when the FIFO drains to empty this cycle
    assign fwd_enq = enq_en && (wr_ptr == rd_ptr_next);

    // Flags straight from the occupancy counter
    assign not_empty = (count != '0);
    assign not_full = (count != CNT_BITS'(N_ENTRIES));

    // RAM write port
    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    // Registered first word
    // Bypass covers the write-then-read collision on the same slot
    always_ff @(posedge clk)
    begin
        if (fwd_enq)
            first <= enq_data;
        else
            first <= mem[rd_ptr_next];
    end

    // Pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            rd_ptr <= rd_ptr_next;
            if (enq_en)
                wr_ptr <= wr_ptr + PTR_BITS'(1);

            // Simultaneous enq and deq leave the count alone
            case ({enq_en, deq_en})
                2'b10: count <= count + CNT_BITS'(1);
                2'b01: count <= count - CNT_BITS'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== common/rdbuf_pkg.sv ====
`include "rdbuf_defines.svh"

package rdbuf_pkg;

    // One data beat as stored in memory and in the buffer
    typedef logic [`RDBUF_DATA_BITS-1:0] t_data;

    // Word address into the beat memory
    typedef logic [`RDBUF_ADDR_BITS-1:0] t_addr;

    // Burst length, one extra bit so MAX_BURST itself fits
    typedef logic [$clog2(`RDBUF_MAX_BURST):0] t_burst_len;

    // Buffer occupancy, zero up to N_ENTRIES inclusive
    typedef logic [$clog2(`RDBUF_N_ENTRIES):0] t_slot_cnt;

    // Requester FSM
    // Idle waits for a command, issue walks the burst one beat per cycle
    typedef enum logic
    {
        REQ_IDLE,
        REQ_ISSUE
    } t_req_state;

endpackage

// ==== common/rdbuf_defines.svh ====
`ifndef RDBUF_DEFINES_SVH
`define RDBUF_DEFINES_SVH

// Sizing of the read-response buffer subsystem

// Buffer depth in beats
// Must stay a power of two for the FIFO pointer wrap
`define RDBUF_N_ENTRIES 32

// Width of one data beat
`define RDBUF_DATA_BITS 32

// Memory word address width
// Six bits give a 64-word backing store
`define RDBUF_ADDR_BITS 6

// Longest burst a command may ask for
// Also the largest number of slots claimed in one cycle
`define RDBUF_MAX_BURST 4

`endif
